//--- include/corebus_cfg.svh
/*
  Core bus configuration.
  Bus widths, channel FIFO sizing and the size of the memory target.
*/
`ifndef COREBUS_CFG_SVH
`define COREBUS_CFG_SVH

`define CB_ADDR_W          8   // byte-free word address.
`define CB_DATA_W          32
`define CB_ID_W            4

`define CB_FIFO_DEPTH      4
`define CB_FIFO_THRESHOLD  3   // fill level that raises almost-full.

// addresses at or above this count are out of range.
`define CB_MEM_WORDS       64

`endif

//--- logic/corebus_pkg.sv
/*
  Core bus types.
  Command kind, the command word and the response word carried on the
  command and response channels of the core bus.
*/
`default_nettype none

`include "corebus_cfg.svh"

package corebus_pkg;

  typedef enum logic {
    CB_READ  = 1'b0,
    CB_WRITE = 1'b1
  } cb_kind_e;

  // 13 bits with the default widths.
  typedef struct packed {
    cb_kind_e               kind;
    logic [`CB_ADDR_W-1:0]  addr;
    logic [`CB_ID_W-1:0]    id;
  } cb_cmd_t;

  // 37 bits with the default widths.
  typedef struct packed {
    logic [`CB_ID_W-1:0]    id;
    logic                   error;  // set for an address beyond the memory.
    logic [`CB_DATA_W-1:0]  data;
  } cb_resp_t;

endpackage

`default_nettype wire

//--- logic/corebus_if.sv
/*
  Core bus interface.
  Command, write data and response channels, each with a valid/accept
  handshake. The master drives requests, the slave drives responses.
*/
`default_nettype none

`include "corebus_cfg.svh"

interface corebus_if;

  logic                   mcmd_valid;
  logic                   scmd_accept;
  corebus_pkg::cb_cmd_t   mcmd;

  logic                   mdata_valid;
  logic                   sdata_accept;
  logic [`CB_DATA_W-1:0]  mdata;

  logic                   sresp_valid;
  logic                   mresp_accept;
  corebus_pkg::cb_resp_t  sresp;

  modport master (
    output mcmd_valid,
    input  scmd_accept,
    output mcmd,
    output mdata_valid,
    input  sdata_accept,
    output mdata,
    input  sresp_valid,
    output mresp_accept,
    input  sresp
  );

  modport slave (
    input  mcmd_valid,
    output scmd_accept,
    input  mcmd,
    input  mdata_valid,
    output sdata_accept,
    input  mdata,
    output sresp_valid,
    input  mresp_accept,
    output sresp
  );

endinterface

`default_nettype wire

//--- logic/channel_fifo.sv
/*
  Channel FIFO.
  Circular buffer for one bus channel with a registered head word and
  registered empty, almost-full and full flags.
*/
`default_nettype none

`include "corebus_cfg.svh"

module channel_fifo #(
  parameter type payload_t = logic,
  parameter int  DEPTH     = `CB_FIFO_DEPTH,
  parameter int  THRESHOLD = `CB_FIFO_THRESHOLD
)(
  input  var logic     i_clk,
  input  var logic     i_arst_n,
  input  var logic     i_clear,
  input  var logic     i_push,
  input  var payload_t i_data,
  input  var logic     i_pop,
  output payload_t     o_data,
  output logic         o_empty,
  output logic         o_almost_full,
  output logic         o_full
);
  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  payload_t         ram [DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [PTR_W-1:0] rd_ptr_next;
  logic [CNT_W-1:0] count;
  logic [CNT_W-1:0] count_next;
  logic             push;
  logic             pop;

  function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
    return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + PTR_W'(1);
  endfunction

  always_comb begin
    push        = i_push && !o_full;  // a push while full is dropped.
    pop         = i_pop && !o_empty;
    rd_ptr_next = pop ? ptr_inc(rd_ptr) : rd_ptr;
    count_next  = count + CNT_W'(push) - CNT_W'(pop);
  end

  always_ff @(posedge i_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      wr_ptr        <= '0;
      rd_ptr        <= '0;
      count         <= '0;
      o_empty       <= 1'b1;
      o_almost_full <= 1'b0;
      o_full        <= 1'b0;
    end else if (i_clear) begin
      wr_ptr        <= '0;
      rd_ptr        <= '0;
      count         <= '0;
      o_empty       <= 1'b1;
      o_almost_full <= 1'b0;
      o_full        <= 1'b0;
    end else begin
      if (push) begin
        wr_ptr <= ptr_inc(wr_ptr);
      end
      rd_ptr        <= rd_ptr_next;
      count         <= count_next;
      o_empty       <= count_next == '0;
      o_almost_full <= count_next >= CNT_W'(THRESHOLD);
      o_full        <= count_next == CNT_W'(DEPTH);
    end
  end

  // The head register takes the pushed word when the buffer would otherwise run dry.
  always_ff @(posedge i_clk) begin
    if (push) begin
      ram[wr_ptr] <= i_data;
    end
    if (push && (count_next == CNT_W'(1))) begin
      o_data <= i_data;
    end else if (pop) begin
      o_data <= ram[rd_ptr_next];  // next entry was written in an earlier cycle.
    end
  end

endmodule

`default_nettype wire

//--- logic/corebus_fifo.sv
/*
  Core bus FIFO.
  Buffers the command, write data and response channels between a bus
  master and a bus target, one channel FIFO each, and reports the fill
  flags per channel (bit 0 command, bit 1 write data, bit 2 response).
*/
`default_nettype none

`include "corebus_cfg.svh"

module corebus_fifo (
  input  var logic    i_clk,
  input  var logic    i_arst_n,
  input  var logic    i_clear,
  output logic [2:0]  o_empty,
  output logic [2:0]  o_almost_full,
  output logic [2:0]  o_full,
  corebus_if.slave    slave_if,
  corebus_if.master   master_if
);

  // requests flow from the slave port toward the master port.
  assign slave_if.scmd_accept  = !o_full[0];
  assign master_if.mcmd_valid  = !o_empty[0];
  assign slave_if.sdata_accept = !o_full[1];
  assign master_if.mdata_valid = !o_empty[1];

  // responses flow the other way.
  assign master_if.mresp_accept = !o_full[2];
  assign slave_if.sresp_valid   = !o_empty[2];

  channel_fifo #(
    .payload_t  (corebus_pkg::cb_cmd_t)
  ) u_cmd_fifo (
    .i_clk          (i_clk                  ),
    .i_arst_n       (i_arst_n               ),
    .i_clear        (i_clear                ),
    .i_push         (slave_if.mcmd_valid    ),
    .i_data         (slave_if.mcmd          ),
    .i_pop          (master_if.scmd_accept  ),
    .o_data         (master_if.mcmd         ),
    .o_empty        (o_empty[0]             ),
    .o_almost_full  (o_almost_full[0]       ),
    .o_full         (o_full[0]              )
  );

  channel_fifo #(
    .payload_t  (logic [`CB_DATA_W-1:0])
  ) u_data_fifo (
    .i_clk          (i_clk                  ),
    .i_arst_n       (i_arst_n               ),
    .i_clear        (i_clear                ),
    .i_push         (slave_if.mdata_valid   ),
    .i_data         (slave_if.mdata         ),
    .i_pop          (master_if.sdata_accept ),
    .o_data         (master_if.mdata        ),
    .o_empty        (o_empty[1]             ),
    .o_almost_full  (o_almost_full[1]       ),
    .o_full         (o_full[1]              )
  );

  channel_fifo #(
    .payload_t  (corebus_pkg::cb_resp_t)
  ) u_resp_fifo (
    .i_clk          (i_clk                  ),
    .i_arst_n       (i_arst_n               ),
    .i_clear        (i_clear                ),
    .i_push         (master_if.sresp_valid  ),
    .i_data         (master_if.sresp        ),
    .i_pop          (slave_if.mresp_accept  ),
    .o_data         (slave_if.sresp         ),
    .o_empty        (o_empty[2]             ),
    .o_almost_full  (o_almost_full[2]       ),
    .o_full         (o_full[2]              )
  );

endmodule

`default_nettype wire

//--- logic/corebus_memory.sv
/*
  Core bus memory target.
  Executes one command at a time on a register array and returns one
  response per command, with an error bit for addresses out of range.
*/
`default_nettype none

`include "corebus_cfg.svh"

module corebus_memory (
  input  var logic  i_clk,
  input  var logic  i_arst_n,
  corebus_if.slave  bus_if
);
  localparam int                    IDX_W      = $clog2(`CB_MEM_WORDS);
  localparam logic [`CB_ADDR_W-1:0] ADDR_LIMIT = `CB_MEM_WORDS;

  logic [`CB_DATA_W-1:0]  mem [`CB_MEM_WORDS];
  corebus_pkg::cb_resp_t  resp;
  logic                   resp_valid;
  logic                   resp_free;
  logic                   is_write;
  logic                   in_range;
  logic                   cmd_take;
  logic [IDX_W-1:0]       index;

  always_comb begin
    resp_free = !resp_valid || bus_if.mresp_accept;  // free or drained this cycle.
    is_write  = bus_if.mcmd.kind == corebus_pkg::CB_WRITE;
    in_range  = bus_if.mcmd.addr < ADDR_LIMIT;
    index     = bus_if.mcmd.addr[IDX_W-1:0];
  end

  // A write takes its command and data beat together.
  always_comb begin
    bus_if.scmd_accept  = resp_free && (!is_write || bus_if.mdata_valid);
    bus_if.sdata_accept = resp_free && bus_if.mcmd_valid && is_write;
    cmd_take            = bus_if.mcmd_valid && bus_if.scmd_accept;
  end

  assign bus_if.sresp_valid = resp_valid;
  assign bus_if.sresp       = resp;

  always_ff @(posedge i_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      resp_valid <= 1'b0;
    end else if (cmd_take) begin
      resp_valid <= 1'b1;
    end else if (bus_if.mresp_accept) begin
      resp_valid <= 1'b0;
    end
  end

  always_ff @(posedge i_clk) begin
    if (cmd_take) begin
      resp.id    <= bus_if.mcmd.id;
      resp.error <= !in_range;
      resp.data  <= (!is_write && in_range) ? mem[index] : '0;
      if (is_write && in_range) begin
        mem[index] <= bus_if.mdata;  // an out-of-range write stores nothing.
      end
    end
  end

endmodule

`default_nettype wire

//--- logic/corebus_top.sv
/*
  Core bus top level.
  Maps the plain master ports onto the core bus, buffers it through the
  channel FIFO block and serves it from the memory target.
*/
`default_nettype none

`include "corebus_cfg.svh"

module corebus_top (
  input  var logic                   i_clk,
  input  var logic                   i_arst_n,
  input  var logic                   i_clear,
  input  var logic                   i_cmd_valid,
  input  var logic                   i_cmd_write,
  input  var logic [`CB_ADDR_W-1:0]  i_cmd_addr,
  input  var logic [`CB_ID_W-1:0]    i_cmd_id,
  input  var logic                   i_data_valid,
  input  var logic [`CB_DATA_W-1:0]  i_data,
  input  var logic                   i_resp_accept,
  output logic                       o_cmd_accept,
  output logic                       o_data_accept,
  output logic                       o_resp_valid,
  output logic [`CB_ID_W-1:0]        o_resp_id,
  output logic                       o_resp_error,
  output logic [`CB_DATA_W-1:0]      o_resp_data,
  output logic [2:0]                 o_empty,
  output logic [2:0]                 o_almost_full,
  output logic [2:0]                 o_full
);
  corebus_if host_bus ();
  corebus_if mem_bus ();

  assign host_bus.mcmd_valid   = i_cmd_valid;
  assign host_bus.mcmd         = '{kind: corebus_pkg::cb_kind_e'(i_cmd_write),
                                   addr: i_cmd_addr,
                                   id:   i_cmd_id};
  assign host_bus.mdata_valid  = i_data_valid;
  assign host_bus.mdata        = i_data;
  assign host_bus.mresp_accept = i_resp_accept;

  assign o_cmd_accept  = host_bus.scmd_accept;
  assign o_data_accept = host_bus.sdata_accept;
  assign o_resp_valid  = host_bus.sresp_valid;
  assign o_resp_id     = host_bus.sresp.id;
  assign o_resp_error  = host_bus.sresp.error;
  assign o_resp_data   = host_bus.sresp.data;

  corebus_fifo u_corebus_fifo (
    .i_clk          (i_clk          ),
    .i_arst_n       (i_arst_n       ),
    .i_clear        (i_clear        ),
    .o_empty        (o_empty        ),
    .o_almost_full  (o_almost_full  ),
    .o_full         (o_full         ),
    .slave_if       (host_bus       ),
    .master_if      (mem_bus        )
  );

  corebus_memory u_corebus_memory (
    .i_clk     (i_clk     ),
    .i_arst_n  (i_arst_n  ),
    .bus_if    (mem_bus   )
  );

endmodule

`default_nettype wire

//--- verification/tb_clock.sv
/*
  Testbench clock.
  Free-running clock for the core bus testbench.
*/
`default_nettype none

module tb_clock #(
  parameter int PERIOD = 8
)(
  output logic o_clk
);
  initial begin
    o_clk = 1'b0;
    forever #(PERIOD / 2) o_clk = ~o_clk;
  end
endmodule

`default_nettype wire

//--- verification/corebus_assert.sv
/*
  Core bus port checks.
  Handshake and flag rules at the plain ports of the core bus top level.
*/
`default_nettype none

`include "corebus_cfg.svh"

module corebus_assert (
  input var logic                  i_clk,
  input var logic                  i_arst_n,
  input var logic                  i_clear,
  input var logic                  i_cmd_valid,
  input var logic                  i_cmd_write,
  input var logic [`CB_ADDR_W-1:0] i_cmd_addr,
  input var logic [`CB_ID_W-1:0]   i_cmd_id,
  input var logic                  i_data_valid,
  input var logic [`CB_DATA_W-1:0] i_data,
  input var logic                  i_resp_accept,
  input var logic                  o_cmd_accept,
  input var logic                  o_data_accept,
  input var logic                  o_resp_valid,
  input var logic [`CB_ID_W-1:0]   o_resp_id,
  input var logic                  o_resp_error,
  input var logic [`CB_DATA_W-1:0] o_resp_data,
  input var logic [2:0]            o_empty,
  input var logic [2:0]            o_almost_full,
  input var logic [2:0]            o_full
);
  // a clear is the only way a stalled response may vanish.
  resp_hold: assert property (@(posedge i_clk) disable iff (!i_arst_n)
    o_resp_valid && !i_resp_accept && !i_clear |=>
      o_resp_valid && $stable({o_resp_id, o_resp_error, o_resp_data}))
    else $error("response dropped or changed while stalled");

  cmd_hold: assert property (@(posedge i_clk) disable iff (!i_arst_n)
    i_cmd_valid && !o_cmd_accept |=>
      i_cmd_valid && $stable({i_cmd_write, i_cmd_addr, i_cmd_id}))
    else $error("command dropped or changed before its transfer");

  data_hold: assert property (@(posedge i_clk) disable iff (!i_arst_n)
    i_data_valid && !o_data_accept |=>
      i_data_valid && $stable(i_data))
    else $error("write data dropped or changed before its transfer");

  // a clear empties all three channels at once.
  clear_empties: assert property (@(posedge i_clk) disable iff (!i_arst_n)
    i_clear |=>
      o_empty == 3'b111 && o_almost_full == 3'b000 && o_full == 3'b000)
    else $error("a channel still holds entries after a clear");
endmodule

bind corebus_top corebus_assert u_corebus_assert (.*);

`default_nettype wire

//--- verification/corebus_tb.sv
/*
  Core bus testbench.
  Directed tests against a reference memory model: reset state, write and
  read, address errors, back-pressure, random traffic and FIFO clear.
*/
`default_nettype none

`include "corebus_cfg.svh"

module corebus_tb;
  localparam int AW    = `CB_ADDR_W;
  localparam int IDW   = `CB_ID_W;
  localparam int IW    = $clog2(`CB_MEM_WORDS);
  localparam int LIMIT = 300;  // cycles allowed for one wait.

  logic                  i_clk;
  logic                  i_arst_n;
  logic                  i_clear;
  logic                  i_cmd_valid;
  logic                  i_cmd_write;
  logic [`CB_ADDR_W-1:0] i_cmd_addr;
  logic [`CB_ID_W-1:0]   i_cmd_id;
  logic                  i_data_valid;
  logic [`CB_DATA_W-1:0] i_data;
  logic                  i_resp_accept;
  logic                  o_cmd_accept;
  logic                  o_data_accept;
  logic                  o_resp_valid;
  logic [`CB_ID_W-1:0]   o_resp_id;
  logic                  o_resp_error;
  logic [`CB_DATA_W-1:0] o_resp_data;
  logic [2:0]            o_empty;
  logic [2:0]            o_almost_full;
  logic [2:0]            o_full;

  logic [`CB_DATA_W-1:0] model [`CB_MEM_WORDS];
  corebus_pkg::cb_resp_t pending [$];  // responses owed, in command order.
  logic [31:0]           rng;
  logic [31:0]           acc_rng;
  int                    errors;
  int                    timeouts;

  tb_clock #(.PERIOD(8)) u_clock (.o_clk(i_clk));

  corebus_top u_dut (.*);

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    return y ^ (y << 5);
  endfunction

  task automatic check_value(input string name, input logic [63:0] actual,
                             input logic [63:0] expected);
    if (actual !== expected) begin
      errors++;
      $display("** Error: %s = 0x%0h, expected 0x%0h", name, actual, expected);
    end
  endtask

  task automatic report_timeout(input string what);
    timeouts++;
    $display("Timed out waiting for %s.", what);
  endtask

  task automatic check_idle();
    @(negedge i_clk);
    check_value("o_empty", 64'(o_empty), 64'h7);
    check_value("o_almost_full", 64'(o_almost_full), 64'h0);
    check_value("o_full", 64'(o_full), 64'h0);
    check_value("o_cmd_accept", 64'(o_cmd_accept), 64'h1);
    check_value("o_data_accept", 64'(o_data_accept), 64'h1);
    check_value("o_resp_valid", 64'(o_resp_valid), 64'h0);
    @(posedge i_clk);
    #1;
  endtask

  // the model is updated in issue order, which is also execution order.
  task automatic send_command(input bit write, input logic [`CB_ADDR_W-1:0] addr,
                              input logic [`CB_ID_W-1:0] id,
                              input logic [`CB_DATA_W-1:0] data);
    corebus_pkg::cb_resp_t exp;
    bit                    cmd_done;
    bit                    data_done;
    int                    cycles;
    exp.id    = id;
    exp.error = int'(addr) >= `CB_MEM_WORDS;
    exp.data  = (write || exp.error) ? '0 : model[addr[IW-1:0]];
    if (write && !exp.error) begin
      model[addr[IW-1:0]] = data;
    end
    cmd_done     = 1'b0;
    data_done    = !write;
    cycles       = 0;
    i_cmd_valid  = 1'b1;
    i_cmd_write  = write;
    i_cmd_addr   = addr;
    i_cmd_id     = id;
    i_data_valid = write;
    i_data       = data;
    while (!(cmd_done && data_done) && cycles < LIMIT) begin
      @(negedge i_clk);
      if (i_cmd_valid && o_cmd_accept) begin
        cmd_done = 1'b1;
        pending.push_back(exp);
      end
      if (i_data_valid && o_data_accept) begin
        data_done = 1'b1;
      end
      @(posedge i_clk);
      #1;
      i_cmd_valid  = !cmd_done;
      i_data_valid = write && !data_done;
      cycles++;
    end
    if (!(cmd_done && data_done)) begin
      report_timeout("the command or write data to be accepted");
    end
  endtask

  task automatic collect_responses(input int count, input bit random_accept);
    corebus_pkg::cb_resp_t exp;
    int                    got;
    int                    cycles;
    got    = 0;
    cycles = 0;
    while (got < count && cycles < LIMIT * count) begin
      if (random_accept) begin
        acc_rng       = xorshift32(acc_rng);
        i_resp_accept = acc_rng[0];
      end else begin
        i_resp_accept = 1'b1;
      end
      @(negedge i_clk);
      if (o_resp_valid && i_resp_accept) begin
        if (pending.size() == 0) begin
          errors++;
          $display("A response arrived with no command outstanding.");
        end else begin
          exp = pending.pop_front();
          check_value("o_resp_id", 64'(o_resp_id), 64'(exp.id));
          check_value("o_resp_error", 64'(o_resp_error), 64'(exp.error));
          check_value("o_resp_data", 64'(o_resp_data), 64'(exp.data));
        end
        got++;
      end
      @(posedge i_clk);
      #1;
      cycles++;
    end
    i_resp_accept = 1'b0;
    if (got < count) begin
      report_timeout("all responses");
    end
  endtask

  task automatic test_write_read(input logic [`CB_ADDR_W-1:0] addr,
                                 input logic [`CB_DATA_W-1:0] data);
    send_command(1'b1, addr, IDW'(3), data);
    send_command(1'b0, addr, IDW'(4), '0);
    collect_responses(2, 1'b0);
  endtask

  task automatic test_address_error();
    send_command(1'b1, AW'(`CB_MEM_WORDS + 5), IDW'(5), 32'hdead_beef);
    send_command(1'b0, AW'(`CB_MEM_WORDS + 5), IDW'(6), '0);
    send_command(1'b0, {AW{1'b1}}, IDW'(7), '0);
    send_command(1'b0, AW'(5), IDW'(8), '0);  // same word index as the bad write.
    collect_responses(4, 1'b0);
  endtask

  task automatic fill_memory();
    fork
      for (int a = 0; a < `CB_MEM_WORDS; a++) begin
        send_command(1'b1, AW'(a), IDW'(a), {~a[7:0], a[7:0], a[7:0] ^ 8'h3c, 8'h5a});
      end
      collect_responses(`CB_MEM_WORDS, 1'b0);
    join
  endtask

  task automatic test_back_pressure();
    int issued;
    bit stalled;
    bit full_seen;
    bit almost_seen;
    issued      = 0;
    stalled     = 1'b0;
    full_seen   = 1'b0;
    almost_seen = 1'b0;
    for (int cycles = 0; cycles < LIMIT; cycles++) begin
      @(negedge i_clk);
      full_seen   |= o_full[0];
      almost_seen |= o_almost_full[2];
      if (!o_cmd_accept) begin
        stalled = 1'b1;
        break;
      end
      @(posedge i_clk);
      #1;
      send_command(1'b0, AW'(issued), IDW'(issued), '0);
      issued++;
    end
    if (!stalled) begin
      report_timeout("o_cmd_accept to drop");
    end
    @(posedge i_clk);
    #1;
    fork
      send_command(1'b0, AW'(issued), IDW'(issued), '0);  // held until accepted.
      collect_responses(issued + 1, 1'b0);
    join
    check_value("o_full[0] seen", 64'(full_seen), 64'h1);
    check_value("o_almost_full[2] seen", 64'(almost_seen), 64'h1);
    check_idle();
  endtask

  task automatic test_random_traffic();
    fork
      begin
        logic [31:0] cmd_bits;
        for (int n = 0; n < 40; n++) begin
          rng      = xorshift32(rng);
          cmd_bits = rng;
          rng      = xorshift32(rng);
          send_command(cmd_bits[31], AW'(cmd_bits[23:8] % `CB_MEM_WORDS),
                       IDW'(cmd_bits), rng);
        end
      end
      collect_responses(40, 1'b1);
    join
    check_idle();
  endtask

  task automatic test_clear();
    int cycles;
    for (int n = 0; n < 3; n++) begin
      send_command(1'b0, AW'(20 + n), IDW'(10 + n), '0);
    end
    cycles = 0;
    while (!(o_empty[0] && o_almost_full[2]) && cycles < LIMIT) begin
      @(posedge i_clk);
      #1;
      cycles++;
    end
    if (!(o_empty[0] && o_almost_full[2])) begin
      report_timeout("responses to queue up");
    end
    i_clear = 1'b1;
    @(posedge i_clk);
    #1;
    i_clear = 1'b0;
    pending.delete();
    cycles  = 0;
    while (o_resp_valid && cycles < LIMIT) begin
      @(posedge i_clk);
      #1;
      cycles++;
    end
    if (o_resp_valid) begin
      report_timeout("o_resp_valid to drop after the clear");
    end
    check_idle();
    test_write_read(AW'(9), 32'h1357_9bdf);
  endtask

  initial begin
    rng           = 32'h8255_4a77;
    acc_rng       = xorshift32(32'h8255_4a77);
    errors        = 0;
    timeouts      = 0;
    i_arst_n      = 1'b0;
    i_clear       = 1'b0;
    i_cmd_valid   = 1'b0;
    i_cmd_write   = 1'b0;
    i_cmd_addr    = '0;
    i_cmd_id      = '0;
    i_data_valid  = 1'b0;
    i_data        = '0;
    i_resp_accept = 1'b0;
    repeat (16) @(posedge i_clk);
    #1;
    i_arst_n = 1'b1;
    check_idle();
    test_write_read(AW'(5), 32'hcafe_0123);
    test_address_error();
    fill_memory();
    test_back_pressure();
    test_random_traffic();
    test_clear();
    $display("Finished with %0d errors and %0d timeouts.", errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end
endmodule

`default_nettype wire

//--- sources.f
+incdir+include
logic/corebus_pkg.sv
logic/corebus_if.sv
logic/channel_fifo.sv
logic/corebus_fifo.sv
logic/corebus_memory.sv
logic/corebus_top.sv
verification/tb_clock.sv
verification/corebus_assert.sv
verification/corebus_tb.sv

//--- Makefile
# Verilator build and run for the core bus testbench.

VERILATOR ?= verilator
TOP       ?= corebus_tb
FILELIST  ?= sources.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

SIM = $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	@$(SIM) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "Test FAILED" $(LOG); then \
	  echo "simulation failed, see $(LOG)"; \
	  exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
